// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := eth_tx_mac_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
RUN_FLAGS  := +verilator+error+limit+1000
FAIL_MSG   := Simulation FAILED
PASS_MSG   := Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: failure reported"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "sim: no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/eth_tx_mac_chk.sv ====
`default_nettype none

module eth_tx_mac_chk (
    input logic clock,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic gmii_tx_en
);

    int fail_count = 0;

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clock) disable iff (reset)
        wb_ack |=> !wb_ack)
    else begin
        $error("wb_ack stayed high for more than one cycle");
        fail_count++;
    end

    ack_after_strobe: assert property (@(posedge clock) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
        $error("wb_ack without a strobe in the cycle before");
        fail_count++;
    end

    tx_idle_after_reset: assert property (@(posedge clock) reset |=> !gmii_tx_en)
    else begin
        $error("gmii_tx_en high in the cycle after reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== dv/eth_tx_mac_mon.sv ====
`default_nettype none

module eth_tx_mac_mon (
    input logic              clock,
    input logic              reset,
    input eth_tx_pkg::byte_t gmii_txd,
    input logic              gmii_tx_en
);

    typedef logic [8*24-1:0] name_t;

    eth_tx_pkg::byte_t exp_bytes [$];
    int                exp_lens  [$];
    name_t             exp_names [$];
    eth_tx_pkg::byte_t cap       [$];
    eth_tx_pkg::crc_t  crc_table [256];
    int                frames_expected = 0;
    int                frames_done     = 0;
    int                mismatch_count  = 0;
    int                fault_count     = 0;
    int                gap             = 0;
    logic              in_frame        = 1'b0;
    logic              had_frame       = 1'b0;

    // byte table for the reflected polynomial
    initial begin
        eth_tx_pkg::crc_t c;
        for (int n = 0; n < 256; n++) begin
            c = eth_tx_pkg::crc_t'(n);
            for (int k = 0; k < 8; k++)
                c = c[0] ? ((c >> 1) ^ eth_tx_pkg::CRC_POLY) : (c >> 1);
            crc_table[n] = c;
        end
    end

    function automatic eth_tx_pkg::crc_t fcs_of(input eth_tx_pkg::byte_t data [$]);
        eth_tx_pkg::crc_t c;
        c = eth_tx_pkg::CRC_INIT;
        foreach (data[i])
            c = crc_table[c[7:0] ^ data[i]] ^ (c >> 8);
        return ~c;
    endfunction

    function automatic name_t next_name();
        if (exp_names.size() != 0)
            return exp_names[0];
        return "unlisted";
    endfunction

    task automatic queue_byte(input eth_tx_pkg::byte_t b);
        exp_bytes.push_back(b);
    endtask

    task automatic queue_frame(input name_t name, input int len);
        exp_names.push_back(name);
        exp_lens.push_back(len);
        frames_expected++;
    endtask

    task automatic check_status(input name_t name, input eth_tx_pkg::wb_data_t want,
                                input eth_tx_pkg::wb_data_t got);
        if (got !== want) begin
            $display("MISMATCH %0s: status expected 0x%02h actual 0x%02h", name, want, got);
            mismatch_count++;
        end
    endtask

    // ------------------------------------------------------------------------
    task automatic check_frame();
        name_t             name;
        int                len;
        int                total;
        eth_tx_pkg::byte_t want;
        eth_tx_pkg::byte_t data [$];
        eth_tx_pkg::crc_t  fcs_got;
        if (exp_lens.size() == 0) begin
            $display("unexpected frame of %0d bytes on GMII, nothing was committed",
                     cap.size());
            fault_count++;
            return;
        end
        name  = exp_names.pop_front();
        len   = exp_lens.pop_front();
        total = eth_tx_pkg::PREAMBLE_LEN + 1 + len + eth_tx_pkg::FCS_LEN;
        for (int i = 0; i < len; i++)
            data.push_back(exp_bytes.pop_front());
        frames_done++;
        if (cap.size() != total) begin
            $display("MISMATCH %0s: tx_en cycles expected %0d actual %0d", name, total,
                     cap.size());
            mismatch_count++;
            return;
        end
        for (int i = 0; i < total - eth_tx_pkg::FCS_LEN; i++) begin
            if (i < eth_tx_pkg::PREAMBLE_LEN)
                want = eth_tx_pkg::PREAMBLE_BYTE;
            else if (i == eth_tx_pkg::PREAMBLE_LEN)
                want = eth_tx_pkg::SFD_BYTE;
            else
                want = data[i - eth_tx_pkg::PREAMBLE_LEN - 1];
            if (cap[i] !== want) begin
                $display("MISMATCH %0s: byte %0d expected 0x%02h actual 0x%02h", name, i,
                         want, cap[i]);
                mismatch_count++;
            end
        end
        fcs_got = {cap[total-1], cap[total-2], cap[total-3], cap[total-4]};  // low byte first
        if (fcs_got !== fcs_of(data)) begin
            $display("MISMATCH %0s: fcs expected 0x%08h actual 0x%08h", name, fcs_of(data),
                     fcs_got);
            mismatch_count++;
        end
    endtask

    task automatic check_end();
        if (in_frame) begin
            $display("a frame was still on GMII when the test sequence ended");
            fault_count++;
        end
        if (exp_lens.size() != 0) begin
            $display("frame %0s and %0d more were committed but never sent", exp_names[0],
                     exp_lens.size() - 1);
            fault_count++;
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clock) begin
        if (reset) begin
            cap.delete();
            in_frame  = 1'b0;
            had_frame = 1'b0;
            gap       = 0;
        end else if (gmii_tx_en) begin
            if (!in_frame) begin
                if (had_frame && gap < eth_tx_pkg::IFG_CYCLES) begin
                    $display("MISMATCH %0s: gap expected >= %0d actual %0d", next_name(),
                             eth_tx_pkg::IFG_CYCLES, gap);
                    mismatch_count++;
                end
                cap.delete();
                in_frame = 1'b1;
            end
            cap.push_back(gmii_txd);
        end else begin
            if (in_frame) begin
                check_frame();
                in_frame  = 1'b0;
                had_frame = 1'b1;
                gap       = 0;
            end
            gap++;
        end
    end

endmodule

`default_nettype wire

// ==== dv/eth_tx_mac_tb.sv ====
`default_nettype none

module eth_tx_mac_tb;

    typedef logic [8*24-1:0] name_t;

    localparam int ACK_LIMIT   = 16;
    localparam int DRAIN_LIMIT = 5000;

    logic                 clock;
    logic                 reset;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    eth_tx_pkg::wb_adr_t  wb_adr;
    eth_tx_pkg::wb_data_t wb_dat_w;
    eth_tx_pkg::wb_data_t wb_dat_r;
    logic                 wb_ack;
    eth_tx_pkg::byte_t    gmii_txd;
    logic                 gmii_tx_en;
    logic [15:0]          lfsr;
    int                   tb_errors;

    eth_tx_mac i_dut (
        .clock      (clock),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

    eth_tx_mac_mon i_mon (
        .clock      (clock),
        .reset      (reset),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

    eth_tx_mac_chk i_chk (
        .clock      (clock),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_ack     (wb_ack),
        .gmii_tx_en (gmii_tx_en)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_byte(output eth_tx_pkg::byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};    // one step per bit
        end
    endtask

    // ------------------------------------------------------------------------
    // one classic cycle that returns the read data
    task automatic bus_cycle(input name_t name, input logic we,
                             input eth_tx_pkg::wb_adr_t adr,
                             input eth_tx_pkg::wb_data_t dat,
                             output eth_tx_pkg::wb_data_t rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            @(posedge clock);
            #1;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            $display("timeout: %0s got no wb_ack within %0d cycles", name, ACK_LIMIT);
            tb_errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clock);    // strobe low for a cycle
        #1;
    endtask

    task automatic send_frame(input name_t name, input int len,
                              input eth_tx_pkg::byte_t first, input eth_tx_pkg::byte_t step);
        eth_tx_pkg::byte_t    b;
        eth_tx_pkg::wb_data_t rdata;
        for (int i = 0; i < len; i++) begin
            if (step == '0)
                random_byte(b);
            else
                b = eth_tx_pkg::byte_t'(first + i * step);
            bus_cycle(name, 1'b1,
                      eth_tx_pkg::wb_adr_t'((1 << eth_tx_pkg::BUF_WINDOW_BIT) + i),
                      {24'd0, b}, rdata);
            i_mon.queue_byte(b);
        end
        bus_cycle(name, 1'b1, eth_tx_pkg::REG_COMMIT, eth_tx_pkg::wb_data_t'(len), rdata);
        i_mon.queue_frame(name, len);
    endtask

    task automatic wait_drain(input name_t name);
        int waited;
        waited = 0;
        while (i_mon.frames_done < i_mon.frames_expected && waited < DRAIN_LIMIT) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (i_mon.frames_done < i_mon.frames_expected) begin
            $display("timeout: %0s, %0d frame(s) still not sent after %0d cycles", name,
                     i_mon.frames_expected - i_mon.frames_done, DRAIN_LIMIT);
            tb_errors++;
        end
    endtask

    task automatic bad_line(input logic [8*8-1:0] op);
        $display("test file line for command %0s could not be read", op);
        tb_errors++;
    endtask

    // ------------------------------------------------------------------------
    task automatic run_tests();
        int                   fd;
        int                   num;
        logic [8*8-1:0]       op;
        logic [8*128-1:0]     line;
        name_t                name;
        eth_tx_pkg::byte_t    first;
        eth_tx_pkg::byte_t    step;
        eth_tx_pkg::wb_data_t value;
        eth_tx_pkg::wb_data_t rdata;
        fd = $fopen("dv/eth_tx_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/eth_tx_tests.txt");
            tb_errors++;
            return;
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                void'($fgets(line, fd));
            end else if (op == "F") begin
                if ($fscanf(fd, "%s %d %h %h", name, num, first, step) == 4)
                    send_frame(name, num, first, step);
                else
                    bad_line(op);
            end else if (op == "S") begin
                if ($fscanf(fd, "%s %h", name, value) == 2) begin
                    bus_cycle(name, 1'b0, eth_tx_pkg::REG_STATUS, '0, rdata);
                    i_mon.check_status(name, value, rdata);
                end else begin
                    bad_line(op);
                end
            end else if (op == "W") begin
                if ($fscanf(fd, "%s %h", name, value) == 2)
                    bus_cycle(name, 1'b1, eth_tx_pkg::REG_CTRL, value, rdata);
                else
                    bad_line(op);
            end else if (op == "R") begin
                if ($fscanf(fd, "%s %d", name, num) == 2)    // commit that must bounce
                    bus_cycle(name, 1'b1, eth_tx_pkg::REG_COMMIT,
                              eth_tx_pkg::wb_data_t'(num), rdata);
                else
                    bad_line(op);
            end else if (op == "I") begin
                if ($fscanf(fd, "%s %d", name, num) == 2) begin
                    repeat (num) @(posedge clock);
                    #1;
                end else begin
                    bad_line(op);
                end
            end else if (op == "D") begin
                if ($fscanf(fd, "%s", name) == 1)
                    wait_drain(name);
                else
                    bad_line(op);
            end else begin
                $display("unknown command %0s in test file", op);
                tb_errors++;
                void'($fgets(line, fd));
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int total;
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        lfsr      = 16'd83;
        tb_errors = 0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        @(posedge clock);
        #1;
        run_tests();
        i_mon.check_end();
        total = i_mon.mismatch_count + i_mon.fault_count + i_chk.fail_count + tb_errors;
        $display("errors: %0d mismatch, %0d frame, %0d assertion, %0d bus or timeout",
                 i_mon.mismatch_count, i_mon.fault_count, i_chk.fail_count, tb_errors);
        if (total == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/eth_tx_tests.txt ====
# F name len first step : frame, byte i = first + i*step (hex), step 00 takes lfsr bytes
# S name status : expected status (hex), W name ctrl (hex), R name len : rejected commit
S reset_status 00
I reset_quiet 50
W enable_tx 01
S enabled 20
F single_60 60 00 01
D single_60_drain
F burst_len1 1 a7 01
F burst_len17 17 10 05
F burst_len256 256 00 00
D burst_drain
S burst_done 20
W hold_tx 00
F hold_a 40 11 03
F hold_b 8 f0 01
F hold_c 100 00 00
F hold_d 5 3c 09
S hold_full 0c
R hold_overflow 20
S hold_err 1c
I hold_quiet 300
S hold_still 1c
W release_tx 01
D release_drain
S release_done 30
W clear_err 03
S err_cleared 20
R zero_len 0
S zero_len_err 30
W zero_len_clear 03
S zero_len_cleared 20
I final_quiet 100
D final_drain

// ==== flist.f ====
verilog/eth_tx_pkg.sv
verilog/frame_wr_if.sv
verilog/frame_rd_if.sv
verilog/tx_host_regs.sv
verilog/tx_frame_ram.sv
verilog/crc32_engine.sv
verilog/gmii_tx_framer.sv
verilog/eth_tx_mac.sv
dv/eth_tx_mac_mon.sv
dv/eth_tx_mac_chk.sv
dv/eth_tx_mac_tb.sv

// ==== verilog/crc32_engine.sv ====
`default_nettype none

module crc32_engine (
    input  logic              clock,
    input  logic              reset,
    input  logic              crc_clear,
    input  logic              crc_step,
    input  logic              fcs_shift,
    input  eth_tx_pkg::byte_t crc_data,
    output eth_tx_pkg::byte_t fcs_byte
);

    eth_tx_pkg::crc_t crc;

    // folds in one byte lsb first
    function automatic eth_tx_pkg::crc_t crc_fold(input eth_tx_pkg::crc_t c_in,
                                                 input eth_tx_pkg::byte_t d);
        eth_tx_pkg::crc_t c;
        c = c_in ^ {24'h0, d};
        for (int i = 0; i < 8; i++)
            c = c[0] ? ((c >> 1) ^ eth_tx_pkg::CRC_POLY) : (c >> 1);
        return c;
    endfunction

    always_ff @(posedge clock) begin
        if (reset || crc_clear)
            crc <= eth_tx_pkg::CRC_INIT;
        else if (crc_step)
            crc <= crc_fold(crc, crc_data);
        else if (fcs_shift)
            crc <= {8'h00, crc[31:8]};    // next fcs byte down
    end

    assign fcs_byte = ~crc[7:0];

endmodule

`default_nettype wire

// ==== verilog/eth_tx_mac.sv ====
`default_nettype none

module eth_tx_mac (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  eth_tx_pkg::wb_adr_t  wb_adr,
    input  eth_tx_pkg::wb_data_t wb_dat_w,
    output eth_tx_pkg::wb_data_t wb_dat_r,
    output logic                 wb_ack,
    output eth_tx_pkg::byte_t    gmii_txd,
    output logic                 gmii_tx_en
);

    logic              tx_valid;
    eth_tx_pkg::slot_t tx_slot;
    logic              tx_sent;
    logic              crc_clear;
    logic              crc_step;
    logic              fcs_shift;
    eth_tx_pkg::byte_t crc_data;
    eth_tx_pkg::byte_t fcs_byte;

    frame_wr_if wr_bus ();
    frame_rd_if rd_bus ();

    // ------------------------------------------------------------------------
    tx_host_regs i_regs (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wr       (wr_bus),
        .tx_valid (tx_valid),
        .tx_slot  (tx_slot),
        .tx_sent  (tx_sent)
    );

    tx_frame_ram i_ram (
        .clock (clock),
        .wr    (wr_bus),
        .rd    (rd_bus)
    );

    gmii_tx_framer i_framer (
        .clock      (clock),
        .reset      (reset),
        .tx_valid   (tx_valid),
        .tx_slot    (tx_slot),
        .tx_sent    (tx_sent),
        .rd         (rd_bus),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .crc_clear  (crc_clear),
        .crc_step   (crc_step),
        .fcs_shift  (fcs_shift),
        .crc_data   (crc_data),
        .fcs_byte   (fcs_byte)
    );

    crc32_engine i_crc (
        .clock     (clock),
        .reset     (reset),
        .crc_clear (crc_clear),
        .crc_step  (crc_step),
        .fcs_shift (fcs_shift),
        .crc_data  (crc_data),
        .fcs_byte  (fcs_byte)
    );

endmodule

`default_nettype wire

// ==== verilog/eth_tx_pkg.sv ====
`default_nettype none

package eth_tx_pkg;

    // ring geometry
    localparam int SLOT_COUNT  = 4;
    localparam int FRAME_BYTES = 256;

    typedef logic [1:0]  slot_t;
    typedef logic [7:0]  byte_index_t;
    typedef logic [8:0]  frame_len_t;     // 0 .. 256
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;
    typedef logic [9:0]  wb_adr_t;
    typedef logic [31:0] wb_data_t;

    // ------------------------------------------------------------------------
    // register map with the byte window at address bit 9
    localparam wb_adr_t REG_COMMIT     = 10'd0;
    localparam wb_adr_t REG_STATUS     = 10'd1;
    localparam wb_adr_t REG_CTRL       = 10'd2;
    localparam int      BUF_WINDOW_BIT = 9;

    // ------------------------------------------------------------------------
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd5;
    localparam int    PREAMBLE_LEN  = 7;
    localparam int    FCS_LEN       = 4;
    localparam int    IFG_CYCLES    = 12;
    localparam crc_t  CRC_INIT      = 32'hffff_ffff;
    localparam crc_t  CRC_POLY      = 32'hedb8_8320;  // reflected form

    typedef enum logic [2:0] {IDLE, PREAMBLE, SFD, DATA, FCS, GAP} framer_state_t;

endpackage

`default_nettype wire

// ==== verilog/frame_rd_if.sv ====
`default_nettype none

interface frame_rd_if;
    eth_tx_pkg::slot_t       slot;
    eth_tx_pkg::byte_index_t index;
    eth_tx_pkg::byte_t       data;   // one cycle after slot/index
    eth_tx_pkg::frame_len_t  len;

    modport framer (output slot, index, input data, len);
    modport ram    (input slot, index, output data, len);
endinterface

`default_nettype wire

// ==== verilog/frame_wr_if.sv ====
`default_nettype none

// host side writes into the slot ring
interface frame_wr_if;
    eth_tx_pkg::slot_t       slot;
    eth_tx_pkg::byte_index_t index;
    eth_tx_pkg::byte_t       data;
    logic                    write;
    eth_tx_pkg::frame_len_t  len;
    logic                    len_write;

    modport host (output slot, index, data, write, len, len_write);
    modport ram  (input  slot, index, data, write, len, len_write);
endinterface

`default_nettype wire

// ==== verilog/gmii_tx_framer.sv ====
`default_nettype none

module gmii_tx_framer (
    input  logic              clock,
    input  logic              reset,
    input  logic              tx_valid,
    input  eth_tx_pkg::slot_t tx_slot,
    output logic              tx_sent,
    frame_rd_if.framer        rd,
    output eth_tx_pkg::byte_t gmii_txd,
    output logic              gmii_tx_en,
    output logic              crc_clear,
    output logic              crc_step,
    output logic              fcs_shift,
    output eth_tx_pkg::byte_t crc_data,
    input  eth_tx_pkg::byte_t fcs_byte
);

    eth_tx_pkg::framer_state_t state;
    eth_tx_pkg::slot_t         cur_slot;
    eth_tx_pkg::frame_len_t    cur_len;
    eth_tx_pkg::frame_len_t    pos;      // byte being read this cycle
    logic [3:0]                cnt;

    // slot read starts while still idle
    assign rd.slot  = (state == eth_tx_pkg::IDLE) ? tx_slot : cur_slot;
    assign rd.index = pos[7:0];

    assign crc_clear = (state == eth_tx_pkg::IDLE);
    assign crc_step  = (state == eth_tx_pkg::DATA);
    assign crc_data  = rd.data;
    assign fcs_shift = (state == eth_tx_pkg::FCS);

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= eth_tx_pkg::IDLE;
            gmii_tx_en <= 1'b0;
            tx_sent    <= 1'b0;
            cnt        <= '0;
            pos        <= '0;
        end else begin
            gmii_tx_en <= 1'b0;
            gmii_txd   <= '0;
            tx_sent    <= 1'b0;
            case (state)
                eth_tx_pkg::IDLE: begin
                    if (tx_valid) begin
                        cur_slot <= tx_slot;
                        cnt      <= '0;
                        pos      <= '0;
                        state    <= eth_tx_pkg::PREAMBLE;
                    end
                end
                eth_tx_pkg::PREAMBLE: begin
                    if (cnt == '0)
                        cur_len <= rd.len;          // length read has landed
                    gmii_tx_en <= 1'b1;
                    gmii_txd   <= eth_tx_pkg::PREAMBLE_BYTE;
                    if (cnt == 4'(eth_tx_pkg::PREAMBLE_LEN - 1)) begin
                        cnt   <= '0;
                        state <= eth_tx_pkg::SFD;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                eth_tx_pkg::SFD: begin
                    gmii_tx_en <= 1'b1;
                    gmii_txd   <= eth_tx_pkg::SFD_BYTE;
                    pos        <= pos + 1'b1;       // byte 0 already requested
                    state      <= eth_tx_pkg::DATA;
                end
                eth_tx_pkg::DATA: begin
                    gmii_tx_en <= 1'b1;
                    gmii_txd   <= rd.data;
                    if (pos == cur_len)
                        state <= eth_tx_pkg::FCS;
                    else
                        pos <= pos + 1'b1;
                end
                eth_tx_pkg::FCS: begin
                    gmii_tx_en <= 1'b1;
                    gmii_txd   <= fcs_byte;
                    if (cnt == 4'(eth_tx_pkg::FCS_LEN - 1)) begin
                        cnt     <= '0;
                        tx_sent <= 1'b1;            // frees the slot
                        state   <= eth_tx_pkg::GAP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                eth_tx_pkg::GAP: begin
                    if (cnt == 4'(eth_tx_pkg::IFG_CYCLES - 1))
                        state <= eth_tx_pkg::IDLE;
                    else
                        cnt <= cnt + 1'b1;
                end
                default: state <= eth_tx_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tx_frame_ram.sv ====
`default_nettype none

module tx_frame_ram (
    input  logic     clock,
    frame_wr_if.ram  wr,
    frame_rd_if.ram  rd
);

    // ------------------------------------------------------------------------
    // slot bytes and lengths
    eth_tx_pkg::byte_t      mem     [eth_tx_pkg::SLOT_COUNT][eth_tx_pkg::FRAME_BYTES];
    eth_tx_pkg::frame_len_t len_mem [eth_tx_pkg::SLOT_COUNT];

    // host port
    always_ff @(posedge clock) begin
        if (wr.write)
            mem[wr.slot][wr.index] <= wr.data;
        if (wr.len_write)
            len_mem[wr.slot] <= wr.len;
    end

    // registered framer port
    always_ff @(posedge clock) begin
        rd.data <= mem[rd.slot][rd.index];
        rd.len  <= len_mem[rd.slot];
    end

endmodule

`default_nettype wire

// ==== verilog/tx_host_regs.sv ====
`default_nettype none

module tx_host_regs (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  eth_tx_pkg::wb_adr_t  wb_adr,
    input  eth_tx_pkg::wb_data_t wb_dat_w,
    output eth_tx_pkg::wb_data_t wb_dat_r,
    output logic                 wb_ack,
    frame_wr_if.host             wr,
    output logic                 tx_valid,
    output eth_tx_pkg::slot_t    tx_slot,
    input  logic                 tx_sent
);

    eth_tx_pkg::slot_t    wr_ptr;
    eth_tx_pkg::slot_t    send_ptr;
    logic [2:0]           pending;     // 0 .. SLOT_COUNT
    logic                 tx_enable;
    logic                 commit_err;
    logic                 req;
    logic                 buf_sel;
    logic                 full;
    logic                 len_ok;
    logic                 commit_req;
    logic                 commit_ok;
    logic                 ctrl_wr;
    logic                 status_rd;
    eth_tx_pkg::wb_data_t status;

    // ------------------------------------------------------------------------
    // one bus request per strobe
    assign req        = wb_cyc & wb_stb & ~wb_ack;
    assign buf_sel    = wb_adr[eth_tx_pkg::BUF_WINDOW_BIT];
    assign full       = (pending == 3'(eth_tx_pkg::SLOT_COUNT));
    assign len_ok     = (wb_dat_w != '0) &&
                        (wb_dat_w <= eth_tx_pkg::wb_data_t'(eth_tx_pkg::FRAME_BYTES));
    assign commit_req = req & wb_we & (wb_adr == eth_tx_pkg::REG_COMMIT);
    assign commit_ok  = commit_req & len_ok & ~full;
    assign ctrl_wr    = req & wb_we & (wb_adr == eth_tx_pkg::REG_CTRL);
    assign status_rd  = req & ~wb_we & (wb_adr == eth_tx_pkg::REG_STATUS);
    assign status     = {26'd0, tx_enable, commit_err, full, pending};

    assign wr.slot      = wr_ptr;
    assign wr.index     = wb_adr[7:0];
    assign wr.data      = wb_dat_w[7:0];
    assign wr.write     = req & wb_we & buf_sel & ~full;  // dropped while the ring is full
    assign wr.len       = wb_dat_w[8:0];
    assign wr.len_write = commit_ok;

    assign tx_valid = tx_enable & (pending != '0);
    assign tx_slot  = send_ptr;                           // oldest pending

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack     <= 1'b0;
            wr_ptr     <= '0;
            send_ptr   <= '0;
            pending    <= '0;
            tx_enable  <= 1'b0;
            commit_err <= 1'b0;
        end else begin
            wb_ack <= req;
            if (commit_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (tx_sent)
                send_ptr <= send_ptr + 1'b1;
            pending <= pending + 3'(commit_ok) - 3'(tx_sent);
            if (commit_req && !commit_ok)
                commit_err <= 1'b1;                       // sticky
            else if (ctrl_wr && wb_dat_w[1])
                commit_err <= 1'b0;
            if (ctrl_wr)
                tx_enable <= wb_dat_w[0];
        end
    end

    // read data sits beside the ack
    always_ff @(posedge clock)
        wb_dat_r <= status_rd ? status : '0;

endmodule

`default_nettype wire
